// ==== l1d_pkg.sv ====
package l1d_pkg;

	// ------------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------------
	localparam int ADDR_W   = 32;
	localparam int DATA_W   = 32;
	localparam int LINE_W   = 128;
	localparam int WAY_NUM  = 2;
	localparam int SET_NUM  = 16;
	localparam int OFFSET_W = 4;
	localparam int IDX_W    = 4;
	localparam int TAG_W    = ADDR_W - IDX_W - OFFSET_W;
	localparam int BE_W     = 4;

	// Byte within a word, word within a line
	localparam int BYTE_OFF_W = 2;
	localparam int WORD_OFF_W = OFFSET_W - BYTE_OFF_W;

	// Access size, log2 of the byte count
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	// ------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {
		COP_RD   = 2'd0,
		COP_WR   = 2'd1,
		COP_RDNC = 2'd2,
		COP_WRNC = 2'd3
	} core_cop_e;

	// Write data sits in its byte lanes of the word
	typedef struct packed {
		core_cop_e           cop;
		logic [ADDR_W-1:0]   addr;
		logic [DATA_W-1:0]   wdata;
		logic [1:0]          size;
	} core_req_t;

	typedef struct packed {
		logic                nc;
		logic                we;
		logic [ADDR_W-1:0]   addr;
		logic [DATA_W-1:0]   wdata;
		logic [BE_W-1:0]     be;
	} mau_req_t;

	typedef logic [LINE_W-1:0] line_t;

	typedef struct packed {
		logic                valid;
		logic [TAG_W-1:0]    tag;
	} tag_entry_t;

	typedef struct packed {
		logic                hit;
		logic [WAY_NUM-1:0]  hit_way;
		logic [WAY_NUM-1:0]  victim_way;
	} lookup_t;

	typedef logic [WAY_NUM-1:0][LINE_W-1:0] line_vec_t;

endpackage

// ==== l1_way_mem.sv ====
`timescale 1ns/100ps

module l1_way_mem #(
	parameter type entry_t = logic
) (
	input  logic                       clk,
	input  logic                       en,
	input  logic                       we,
	input  logic [l1d_pkg::IDX_W-1:0]  addr,
	input  entry_t                     wdata,
	output entry_t                     rdata
);

	entry_t mem [l1d_pkg::SET_NUM];

	// Read data only moves on a read, so it holds through a write
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// ==== l1d_tag_array.sv ====
`timescale 1ns/100ps

module l1d_tag_array (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          lookup_en,
	input  logic [l1d_pkg::ADDR_W-1:0]    addr,
	input  logic                          refill,
	input  logic                          hit_update,
	input  logic [l1d_pkg::WAY_NUM-1:0]   way_sel,
	output l1d_pkg::lookup_t              lookup
);

	logic [l1d_pkg::IDX_W-1:0]                        idx;
	logic [l1d_pkg::TAG_W-1:0]                        tag;
	logic [l1d_pkg::TAG_W-1:0]                        tag_r;
	logic [l1d_pkg::SET_NUM-1:0][l1d_pkg::WAY_NUM-1:0] valid;
	logic [l1d_pkg::SET_NUM-1:0]                      lru;
	logic [l1d_pkg::WAY_NUM-1:0]                      valid_r;
	logic                                             lru_r;
	logic [l1d_pkg::WAY_NUM-1:0]                      hit_vec;
	logic [l1d_pkg::WAY_NUM-1:0]                      victim;
	l1d_pkg::tag_entry_t                              wr_entry;
	l1d_pkg::tag_entry_t                              rd_entry [l1d_pkg::WAY_NUM];

	assign idx = addr[l1d_pkg::OFFSET_W +: l1d_pkg::IDX_W];
	assign tag = addr[l1d_pkg::ADDR_W-1 -: l1d_pkg::TAG_W];

	assign wr_entry.valid = 1'b1;
	assign wr_entry.tag   = tag;

	// ------------------------------------------------------------------
	// Valid and LRU state
	// ------------------------------------------------------------------
	// lru holds the index of the least recently used way
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid   <= '0;
			lru     <= '0;
			valid_r <= '0;
			lru_r   <= 1'b0;
		end else begin
			if (refill) begin
				valid[idx] <= valid[idx] | way_sel;
			end
			if (refill || hit_update) begin
				lru[idx] <= way_sel[0];
			end
			// Snapshot for the set, stable until the next lookup
			if (lookup_en) begin
				valid_r <= valid[idx];
				lru_r   <= lru[idx];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_en) begin
			tag_r <= tag;
		end
	end

	// ------------------------------------------------------------------
	// Tag memories and compare
	// ------------------------------------------------------------------
	for (genvar w = 0; w < l1d_pkg::WAY_NUM; w++) begin : g_way
		l1_way_mem #(
			.entry_t (l1d_pkg::tag_entry_t)
		) u_mem (
			.clk   (clk),
			.en    (lookup_en | (refill & way_sel[w])),
			.we    (refill & way_sel[w]),
			.addr  (idx),
			.wdata (wr_entry),
			.rdata (rd_entry[w])
		);

		assign hit_vec[w] = valid_r[w] & rd_entry[w].valid & (rd_entry[w].tag == tag_r);
	end

	// First invalid way wins, else the LRU way
	always_comb begin
		victim        = '0;
		victim[lru_r] = 1'b1;
		for (int w = l1d_pkg::WAY_NUM - 1; w >= 0; w--) begin
			if (!valid_r[w]) begin
				victim    = '0;
				victim[w] = 1'b1;
			end
		end
	end

	assign lookup.hit        = |hit_vec;
	assign lookup.hit_way    = hit_vec;
	assign lookup.victim_way = victim;

endmodule

// ==== l1d_data_array.sv ====
`timescale 1ns/100ps

module l1d_data_array (
	input  logic                          clk,
	input  logic                          lookup_en,
	input  logic [l1d_pkg::ADDR_W-1:0]    addr,
	input  logic                          refill,
	input  logic                          write_hit,
	input  logic [l1d_pkg::WAY_NUM-1:0]   way_sel,
	input  l1d_pkg::line_t                refill_line,
	input  logic [l1d_pkg::DATA_W-1:0]    wdata,
	input  logic [l1d_pkg::BE_W-1:0]      be,
	output l1d_pkg::line_vec_t            rdata
);

	logic [l1d_pkg::IDX_W-1:0]       idx;
	logic [l1d_pkg::WORD_OFF_W-1:0]  word_off;
	logic                            wr_any;
	l1d_pkg::line_t                  merged;
	l1d_pkg::line_t                  wr_line;

	assign idx      = addr[l1d_pkg::OFFSET_W +: l1d_pkg::IDX_W];
	assign word_off = addr[l1d_pkg::BYTE_OFF_W +: l1d_pkg::WORD_OFF_W];
	assign wr_any   = refill | write_hit;

	// ------------------------------------------------------------------
	// Byte merge into the line read at lookup
	// ------------------------------------------------------------------
	always_comb begin
		merged = '0;
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
			if (way_sel[w]) begin
				merged = merged | rdata[w];
			end
		end
		for (int b = 0; b < l1d_pkg::BE_W; b++) begin
			if (be[b]) begin
				merged[word_off * l1d_pkg::DATA_W + b * 8 +: 8] = wdata[b * 8 +: 8];
			end
		end
	end

	assign wr_line = refill ? refill_line : merged;

	// ------------------------------------------------------------------
	// Line memories
	// ------------------------------------------------------------------
	for (genvar w = 0; w < l1d_pkg::WAY_NUM; w++) begin : g_way
		l1_way_mem #(
			.entry_t (l1d_pkg::line_t)
		) u_mem (
			.clk   (clk),
			.en    (lookup_en | (wr_any & way_sel[w])),
			.we    (wr_any & way_sel[w]),
			.addr  (idx),
			.wdata (wr_line),
			.rdata (rdata[w])
		);
	end

endmodule

// ==== l1d_ctrl.sv ====
`timescale 1ns/100ps

module l1d_ctrl (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          core_req_val,
	input  l1d_pkg::core_req_t            core_req,
	output logic                          core_req_ack,
	output logic [l1d_pkg::DATA_W-1:0]    core_ack_data,
	output logic                          mau_req_val,
	output l1d_pkg::mau_req_t             mau_req,
	input  logic                          mau_req_ack,
	input  l1d_pkg::line_t                mau_ack_data,
	output logic                          lookup_en,
	output logic                          refill,
	output logic                          write_hit,
	output logic                          hit_update,
	output logic [l1d_pkg::ADDR_W-1:0]    req_addr,
	output logic [l1d_pkg::WAY_NUM-1:0]   way_sel,
	output logic [l1d_pkg::DATA_W-1:0]    wdata,
	output logic [l1d_pkg::BE_W-1:0]      be,
	input  l1d_pkg::lookup_t              lookup,
	input  l1d_pkg::line_vec_t            rdata
);

	typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_MAU, ST_RESP} state_e;

	state_e                          state;
	state_e                          state_nxt;
	l1d_pkg::core_req_t              req_r;
	l1d_pkg::line_t                  mau_line_r;
	l1d_pkg::line_t                  hit_line;
	l1d_pkg::line_t                  resp_line;
	logic                            req_rd;
	logic                            req_nc;
	logic                            req_wr;
	logic                            rd_hit;
	logic                            mau_done;
	logic [l1d_pkg::BE_W-1:0]        be_base;
	logic [l1d_pkg::WORD_OFF_W-1:0]  word_off;

	// ------------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:   if (core_req_val) state_nxt = ST_LOOKUP;
			ST_LOOKUP: begin
				if (rd_hit) begin
					state_nxt = ST_IDLE;
				end else if (mau_req_ack) begin
					state_nxt = ST_RESP;
				end else begin
					state_nxt = ST_MAU;
				end
			end
			ST_MAU:    if (mau_req_ack) state_nxt = ST_RESP;
			default:   state_nxt = ST_IDLE;
		endcase
	end

	// Request and returned line
	always_ff @(posedge clk) begin
		if (lookup_en) begin
			req_r <= core_req;
		end
		if (mau_done) begin
			mau_line_r <= mau_ack_data;
		end
	end

	assign req_rd = (req_r.cop == l1d_pkg::COP_RD);
	assign req_nc = (req_r.cop == l1d_pkg::COP_RDNC) || (req_r.cop == l1d_pkg::COP_WRNC);
	assign req_wr = (req_r.cop == l1d_pkg::COP_WR) || (req_r.cop == l1d_pkg::COP_WRNC);

	assign rd_hit   = (state == ST_LOOKUP) && req_rd && lookup.hit;
	assign mau_done = mau_req_val && mau_req_ack;

	// ------------------------------------------------------------------
	// Array control
	// ------------------------------------------------------------------
	assign lookup_en  = (state == ST_IDLE) && core_req_val;
	assign req_addr   = (state == ST_IDLE) ? core_req.addr : req_r.addr;
	assign refill     = mau_done && req_rd;
	assign write_hit  = mau_done && (req_r.cop == l1d_pkg::COP_WR) && lookup.hit;
	assign hit_update = (state == ST_LOOKUP) && !req_nc && lookup.hit;
	assign way_sel    = refill ? lookup.victim_way : lookup.hit_way;
	assign wdata      = req_r.wdata;

	always_comb begin
		case (req_r.size)
			l1d_pkg::SIZE_BYTE: be_base = 4'b0001;
			l1d_pkg::SIZE_HALF: be_base = 4'b0011;
			default:            be_base = 4'b1111;
		endcase
	end

	assign be = be_base << req_r.addr[l1d_pkg::BYTE_OFF_W-1:0];

	// ------------------------------------------------------------------
	// MAU request
	// ------------------------------------------------------------------
	assign mau_req_val = ((state == ST_LOOKUP) && !rd_hit) || (state == ST_MAU);

	assign mau_req.nc    = req_nc;
	assign mau_req.we    = req_wr;
	// Refills fetch the whole line
	assign mau_req.addr  = req_rd ?
		{req_r.addr[l1d_pkg::ADDR_W-1:l1d_pkg::OFFSET_W], {l1d_pkg::OFFSET_W{1'b0}}} :
		req_r.addr;
	assign mau_req.wdata = req_r.wdata;
	assign mau_req.be    = be;

	// ------------------------------------------------------------------
	// Core response
	// ------------------------------------------------------------------
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
			if (lookup.hit_way[w]) begin
				hit_line = hit_line | rdata[w];
			end
		end
	end

	assign word_off      = req_r.addr[l1d_pkg::BYTE_OFF_W +: l1d_pkg::WORD_OFF_W];
	assign resp_line     = (state == ST_RESP) ? mau_line_r : hit_line;
	assign core_ack_data = resp_line[word_off * l1d_pkg::DATA_W +: l1d_pkg::DATA_W];
	assign core_req_ack  = rd_hit || (state == ST_RESP);

endmodule

// ==== l1d_top.sv ====
`timescale 1ns/100ps

module l1d_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          core_req_val,
	input  l1d_pkg::core_req_t            core_req,
	output logic                          core_req_ack,
	output logic [l1d_pkg::DATA_W-1:0]    core_ack_data,
	output logic                          mau_req_val,
	output l1d_pkg::mau_req_t             mau_req,
	input  logic                          mau_req_ack,
	input  l1d_pkg::line_t                mau_ack_data
);

	logic                          lookup_en;
	logic                          refill;
	logic                          write_hit;
	logic                          hit_update;
	logic [l1d_pkg::ADDR_W-1:0]    req_addr;
	logic [l1d_pkg::WAY_NUM-1:0]   way_sel;
	logic [l1d_pkg::DATA_W-1:0]    wdata;
	logic [l1d_pkg::BE_W-1:0]      be;
	l1d_pkg::lookup_t              lookup;
	l1d_pkg::line_vec_t            rdata;

	l1d_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.core_req_val  (core_req_val),
		.core_req      (core_req),
		.core_req_ack  (core_req_ack),
		.core_ack_data (core_ack_data),
		.mau_req_val   (mau_req_val),
		.mau_req       (mau_req),
		.mau_req_ack   (mau_req_ack),
		.mau_ack_data  (mau_ack_data),
		.lookup_en     (lookup_en),
		.refill        (refill),
		.write_hit     (write_hit),
		.hit_update    (hit_update),
		.req_addr      (req_addr),
		.way_sel       (way_sel),
		.wdata         (wdata),
		.be            (be),
		.lookup        (lookup),
		.rdata         (rdata)
	);

	l1d_tag_array u_tags (
		.clk        (clk),
		.rst_n      (rst_n),
		.lookup_en  (lookup_en),
		.addr       (req_addr),
		.refill     (refill),
		.hit_update (hit_update),
		.way_sel    (way_sel),
		.lookup     (lookup)
	);

	// Refill line comes straight from the MAU in the acknowledge cycle
	l1d_data_array u_data (
		.clk         (clk),
		.lookup_en   (lookup_en),
		.addr        (req_addr),
		.refill      (refill),
		.write_hit   (write_hit),
		.way_sel     (way_sel),
		.refill_line (mau_ack_data),
		.wdata       (wdata),
		.be          (be),
		.rdata       (rdata)
	);

endmodule

// ==== l1d_properties.sv ====
`timescale 1ns/100ps

module l1d_properties (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  core_req_val,
	input  l1d_pkg::core_req_t    core_req,
	input  logic                  core_req_ack,
	input  logic                  mau_req_val,
	input  l1d_pkg::mau_req_t     mau_req,
	input  logic                  mau_req_ack
);

	logic [1:0] align_mask;

	// Low address bits that must be zero for the access size
	always_comb begin
		case (core_req.size)
			l1d_pkg::SIZE_HALF: align_mask = 2'b01;
			l1d_pkg::SIZE_WORD: align_mask = 2'b11;
			default:            align_mask = 2'b00;
		endcase
	end

	a_mau_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mau_req_val && !mau_req_ack |=> mau_req_val && $stable(mau_req))
		else $error("MAU request changed before its acknowledge");

	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_ack |=> !core_req_ack)
		else $error("core_req_ack high for two cycles in a row");

	a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_val |-> ((core_req.addr[1:0] & align_mask) == 2'b00))
		else $error("core request address not aligned to its size");

endmodule

bind l1d_ctrl l1d_properties u_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.core_req_val (core_req_val),
	.core_req     (core_req),
	.core_req_ack (core_req_ack),
	.mau_req_val  (mau_req_val),
	.mau_req      (mau_req),
	.mau_req_ack  (mau_req_ack)
);

// ==== tb_l1d.sv ====
`timescale 1ns/100ps

module tb_l1d;

	localparam int CYCLE_NS     = 40;
	localparam int DIRECTED_NUM = 22;
	localparam int RAND_NUM     = 200;
	localparam int REQ_NUM      = DIRECTED_NUM + RAND_NUM;
	localparam int ACK_LIMIT    = 20;
	localparam int MEM_LINES    = 256;

	typedef struct packed {
		logic [l1d_pkg::ADDR_W-1:0]  addr;
		logic                        we;
		logic                        nc;
		logic [l1d_pkg::BE_W-1:0]    be;
	} mau_log_t;

	logic                          clk = 1'b0;
	logic                          rst_n;
	logic                          core_req_val;
	l1d_pkg::core_req_t            core_req;
	logic                          core_req_ack;
	logic [l1d_pkg::DATA_W-1:0]    core_ack_data;
	logic                          mau_req_val;
	l1d_pkg::mau_req_t             mau_req;
	logic                          mau_req_ack = 1'b0;
	l1d_pkg::line_t                mau_ack_data = '0;

	// MAU model
	l1d_pkg::line_t  backing [MEM_LINES];
	mau_log_t        mau_log [$];
	logic            mau_busy;
	int unsigned     mau_wait;
	int unsigned     wait_tbl [REQ_NUM];
	int              wait_ptr;

	// Reference model of memory and cache
	l1d_pkg::line_t             ref_mem [MEM_LINES];
	l1d_pkg::line_t             ref_line [l1d_pkg::SET_NUM][l1d_pkg::WAY_NUM];
	logic [l1d_pkg::TAG_W-1:0]  ref_tag [l1d_pkg::SET_NUM][l1d_pkg::WAY_NUM];
	logic                       ref_valid [l1d_pkg::SET_NUM][l1d_pkg::WAY_NUM];
	logic                       ref_lru [l1d_pkg::SET_NUM];

	int           errors;

	l1d_top u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.core_req_val  (core_req_val),
		.core_req      (core_req),
		.core_req_ack  (core_req_ack),
		.core_ack_data (core_ack_data),
		.mau_req_val   (mau_req_val),
		.mau_req       (mau_req),
		.mau_req_ack   (mau_req_ack),
		.mau_ack_data  (mau_ack_data)
	);

	always #(CYCLE_NS / 2) clk = ~clk;

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------
	// Every word carries its own byte address
	function automatic l1d_pkg::line_t fill_line(input int idx);
		l1d_pkg::line_t  line;
		logic [11:0]     a;
		for (int j = 0; j < 4; j++) begin
			a = 12'(idx * 16 + j * 4);
			line[j * 32 +: 32] = {8'hd1, a, ~a};
		end
		return line;
	endfunction

	function automatic logic [3:0] byte_en(input logic [1:0] size, input logic [1:0] off);
		case (size)
			l1d_pkg::SIZE_BYTE: return 4'b0001 << off;
			l1d_pkg::SIZE_HALF: return 4'b0011 << off;
			default:            return 4'b1111;
		endcase
	endfunction

	function automatic l1d_pkg::line_t merge_word(input l1d_pkg::line_t line,
			input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] be);
		l1d_pkg::line_t  res;
		int              pos;
		res = line;
		for (int b = 0; b < 4; b++) begin
			pos = int'(addr[3:2]) * 32 + b * 8;
			if (be[b]) begin
				res[pos +: 8] = wdata[b * 8 +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [31:0] word_of(input l1d_pkg::line_t line, input logic [31:0] addr);
		return line[int'(addr[3:2]) * 32 +: 32];
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Fail %0t ns: %s", $time, msg);
		errors++;
	endtask

	// ------------------------------------------------------------------
	// MAU model, waits taken from a table filled by the seeded process
	// ------------------------------------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			mau_busy = 1'b0;
			mau_wait = 0;
			wait_ptr = 0;
			mau_req_ack <= 1'b0;
			for (int i = 0; i < MEM_LINES; i++) begin
				backing[i] = fill_line(i);
			end
		end else begin
			mau_req_ack <= 1'b0;
			if (mau_req_val && !mau_req_ack) begin
				if (!mau_busy) begin
					mau_busy = 1'b1;
					mau_wait = wait_tbl[wait_ptr % REQ_NUM];
					wait_ptr++;
				end
				if (mau_wait == 0) begin
					mau_log.push_back('{addr: mau_req.addr, we: mau_req.we,
						nc: mau_req.nc, be: mau_req.be});
					if (mau_req.we) begin
						backing[mau_req.addr[11:4]] = merge_word(backing[mau_req.addr[11:4]],
							mau_req.addr, mau_req.wdata, mau_req.be);
					end
					mau_ack_data <= backing[mau_req.addr[11:4]];
					mau_req_ack  <= 1'b1;
					mau_busy = 1'b0;
				end else begin
					mau_wait--;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// One core request, checked against the reference model
	// ------------------------------------------------------------------
	// seen_hit is what the DUT showed: a cacheable read served without the MAU
	task automatic do_req(input l1d_pkg::core_cop_e cop, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [1:0] size, output logic seen_hit);
		logic [l1d_pkg::IDX_W-1:0]  set;
		logic [l1d_pkg::TAG_W-1:0]  tag;
		logic [7:0]                 mline;
		logic [3:0]                 be;
		logic [31:0]                exp_addr;
		logic [31:0]                exp_word;
		logic                       cacheable;
		logic                       is_wr;
		logic                       want_mau;
		logic                       hit;
		int                         way;
		int                         n_log;
		int                         waits;
		mau_log_t                   ent;

		set       = addr[7:4];
		tag       = addr[31:8];
		mline     = addr[11:4];
		be        = byte_en(size, addr[1:0]);
		cacheable = (cop == l1d_pkg::COP_RD) || (cop == l1d_pkg::COP_WR);
		is_wr     = (cop == l1d_pkg::COP_WR) || (cop == l1d_pkg::COP_WRNC);
		hit       = 1'b0;
		seen_hit  = 1'b0;
		way       = 0;
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
			if (cacheable && ref_valid[set][w] && ref_tag[set][w] == tag) begin
				hit = 1'b1;
				way = w;
			end
		end
		want_mau = !(cop == l1d_pkg::COP_RD && hit);
		exp_addr = (cop == l1d_pkg::COP_RD) ? {addr[31:4], 4'h0} : addr;
		exp_word = hit ? word_of(ref_line[set][way], addr) : word_of(ref_mem[mline], addr);
		n_log    = mau_log.size();

		@(posedge clk);
		core_req_val <= 1'b1;
		core_req     <= '{cop: cop, addr: addr, wdata: wdata, size: size};
		waits = 0;
		do begin
			@(negedge clk);
			waits++;
		end while (!core_req_ack && waits <= ACK_LIMIT);

		if (!core_req_ack) begin
			$display("No acknowledge for %s to %h within %0d cycles", cop.name(), addr,
				ACK_LIMIT);
			errors++;
		end else begin
			seen_hit = (cop == l1d_pkg::COP_RD) && (mau_log.size() == n_log);
			if (cop == l1d_pkg::COP_RD && hit && waits != 2) begin
				report_mismatch($sformatf("read hit %h took %0d cycles", addr, waits - 1));
			end
			if (!is_wr && core_ack_data !== exp_word) begin
				report_mismatch($sformatf("%s %h returned %h, expected %h", cop.name(), addr,
					core_ack_data, exp_word));
			end
			if (!want_mau && mau_log.size() != n_log) begin
				report_mismatch($sformatf("read hit %h issued a MAU request", addr));
			end else if (want_mau && mau_log.size() != n_log + 1) begin
				report_mismatch($sformatf("%s %h gave %0d MAU requests, expected 1", cop.name(),
					addr, mau_log.size() - n_log));
			end else if (want_mau) begin
				ent = mau_log[n_log];
				if (ent.addr !== exp_addr || ent.we !== is_wr || ent.nc !== !cacheable) begin
					report_mismatch($sformatf("MAU addr %h we %b nc %b, expected %h %b %b",
						ent.addr, ent.we, ent.nc, exp_addr, is_wr, !cacheable));
				end
				if (is_wr && ent.be !== be) begin
					report_mismatch($sformatf("MAU be %b, expected %b", ent.be, be));
				end
			end
		end
		@(posedge clk);
		core_req_val <= 1'b0;

		// Write-through, no-write-allocate, first invalid way else LRU way
		if (cop == l1d_pkg::COP_RD) begin
			if (!hit) begin
				if (!ref_valid[set][0]) begin
					way = 0;
				end else if (!ref_valid[set][1]) begin
					way = 1;
				end else begin
					way = int'(ref_lru[set]);
				end
				ref_valid[set][way] = 1'b1;
				ref_tag[set][way]   = tag;
				ref_line[set][way]  = ref_mem[mline];
			end
			ref_lru[set] = (way == 0);
		end else if (is_wr) begin
			ref_mem[mline] = merge_word(ref_mem[mline], addr, wdata, be);
			if (hit) begin
				ref_line[set][way] = merge_word(ref_line[set][way], addr, wdata, be);
				ref_lru[set]       = (way == 0);
			end
		end
	endtask

	// ------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------
	task automatic apply_reset();
		rst_n <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic test_read_alloc();
		logic hit;
		repeat (3) begin
			@(negedge clk);
			if (core_req_ack !== 1'b0 || mau_req_val !== 1'b0) begin
				report_mismatch("handshake outputs not low after reset");
			end
		end
		do_req(l1d_pkg::COP_RD, 32'h0000_0104, 32'h0, l1d_pkg::SIZE_WORD, hit);
		do_req(l1d_pkg::COP_RD, 32'h0000_0108, 32'h0, l1d_pkg::SIZE_WORD, hit);
	endtask

	task automatic test_write_through();
		logic hit;
		do_req(l1d_pkg::COP_WR, 32'h0000_0105, 32'h0000_a700, l1d_pkg::SIZE_BYTE, hit);
		do_req(l1d_pkg::COP_WR, 32'h0000_010a, 32'h5c3e_0000, l1d_pkg::SIZE_HALF, hit);
		do_req(l1d_pkg::COP_WR, 32'h0000_010c, 32'h1234_abcd, l1d_pkg::SIZE_WORD, hit);
		do_req(l1d_pkg::COP_RD, 32'h0000_0104, 32'h0, l1d_pkg::SIZE_WORD, hit);
		do_req(l1d_pkg::COP_RD, 32'h0000_0108, 32'h0, l1d_pkg::SIZE_WORD, hit);
		do_req(l1d_pkg::COP_RD, 32'h0000_010c, 32'h0, l1d_pkg::SIZE_WORD, hit);
	endtask

	task automatic test_no_alloc();
		logic hit;
		do_req(l1d_pkg::COP_WR, 32'h0000_0230, 32'hfeed_0230, l1d_pkg::SIZE_WORD, hit);
		do_req(l1d_pkg::COP_RD, 32'h0000_0230, 32'h0, l1d_pkg::SIZE_WORD, hit);
		if (hit) begin
			$display("Read after a write miss hit, so the write allocated a line");
			errors++;
		end
	endtask

	task automatic test_noncacheable();
		logic hit;
		do_req(l1d_pkg::COP_RDNC, 32'h0000_0346, 32'h0, l1d_pkg::SIZE_HALF, hit);
		do_req(l1d_pkg::COP_WRNC, 32'h0000_0348, 32'h0bad_cafe, l1d_pkg::SIZE_WORD, hit);
		do_req(l1d_pkg::COP_RDNC, 32'h0000_0104, 32'h0, l1d_pkg::SIZE_WORD, hit);
		do_req(l1d_pkg::COP_RD, 32'h0000_0348, 32'h0, l1d_pkg::SIZE_WORD, hit);
		if (hit) begin
			$display("Line touched only by non-cacheable accesses was found in the cache");
			errors++;
		end
		// Cached copy stays stale after a non-cacheable write
		do_req(l1d_pkg::COP_WRNC, 32'h0000_0108, 32'h7777_1111, l1d_pkg::SIZE_WORD, hit);
		do_req(l1d_pkg::COP_RD, 32'h0000_0108, 32'h0, l1d_pkg::SIZE_WORD, hit);
	endtask

	task automatic test_lru();
		logic [5:0]  hits;
		logic        hit;
		do_req(l1d_pkg::COP_RD, 32'h0000_0050, 32'h0, l1d_pkg::SIZE_WORD, hits[0]);
		do_req(l1d_pkg::COP_RD, 32'h0000_0154, 32'h0, l1d_pkg::SIZE_WORD, hits[1]);
		do_req(l1d_pkg::COP_RD, 32'h0000_0058, 32'h0, l1d_pkg::SIZE_WORD, hits[2]);
		do_req(l1d_pkg::COP_RD, 32'h0000_025c, 32'h0, l1d_pkg::SIZE_WORD, hits[3]);
		do_req(l1d_pkg::COP_RD, 32'h0000_0050, 32'h0, l1d_pkg::SIZE_WORD, hits[4]);
		do_req(l1d_pkg::COP_RD, 32'h0000_0150, 32'h0, l1d_pkg::SIZE_WORD, hit);
		hits[5] = hit;
		if (hits != 6'b010100) begin
			report_mismatch($sformatf("LRU sequence A B A C A B gave hit pattern %b, expected 010100",
				hits));
		end
	endtask

	task automatic test_random(input int count);
		l1d_pkg::core_cop_e  cop;
		logic [1:0]          size;
		logic [1:0]          off;
		logic [31:0]         addr;
		logic                hit;
		for (int i = 0; i < count; i++) begin
			cop  = l1d_pkg::core_cop_e'(2'($urandom % 4));
			size = 2'($urandom % 3);
			off  = 2'($urandom);
			case (size)
				l1d_pkg::SIZE_HALF: off[0] = 1'b0;
				l1d_pkg::SIZE_WORD: off = 2'b00;
				default: ;
			endcase
			// Three tags per set
			addr = {22'h0, 2'($urandom % 3), 4'($urandom), 2'($urandom), off};
			do_req(cop, addr, $urandom, size, hit);
		end
	endtask

	// ------------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------------
	initial begin
		void'($urandom(32'h97a6e80c));
		errors       = 0;
		rst_n        = 1'b0;
		core_req_val = 1'b0;
		core_req     = '0;
		for (int i = 0; i < REQ_NUM; i++) begin
			wait_tbl[i] = $urandom % 6;
		end
		for (int i = 0; i < MEM_LINES; i++) begin
			ref_mem[i] = fill_line(i);
		end
		for (int s = 0; s < l1d_pkg::SET_NUM; s++) begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_tag[s][w]   = '0;
				ref_line[s][w]  = '0;
			end
		end

		apply_reset();
		test_read_alloc();
		test_write_through();
		test_no_alloc();
		test_noncacheable();
		test_lru();
		test_random(RAND_NUM);

		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(REQ_NUM * 20 * CYCLE_NS);
		$display("Watchdog expired before all %0d requests completed", REQ_NUM);
		$display("Run stopped with %0d errors", errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== l1d.f ====
l1d_pkg.sv
l1_way_mem.sv
l1d_tag_array.sv
l1d_data_array.sv
l1d_ctrl.sv
l1d_top.sv
l1d_properties.sv
tb_l1d.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the L1 data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_l1d -f l1d.f -o sim_l1d

./obj_dir/sim_l1d | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
